//--- flist.f
+incdir+include
hw/scope_pkg.sv
hw/capture_if.sv
hw/stats_if.sv
hw/trigger_capture.sv
hw/sample_stats.sv
hw/scope_regs.sv
hw/scope_top.sv
tests/tb_scope.sv

//--- include/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// bus signals are taken from the including module under their dut port names

task automatic fail(input string msg);
   $display("STATUS: FAIL");
   $display("CHECK FAILED %s", msg);
   $fatal(1, "%s", msg);
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
   assert (got === exp) else begin
      fail($sformatf("%s got=%h exp=%h", name, got, exp));
   end
endtask

// full write of all four bytes that returns bresp
task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
   awaddr  <= addr;
   awvalid <= 1'b1;
   wdata   <= data;
   wstrb   <= 4'hf;
   wvalid  <= 1'b1;
   bready  <= 1'b1;
   do @(posedge clk); while (!awready);
   awvalid <= 1'b0;
   wvalid  <= 1'b0;
   do @(posedge clk); while (!bvalid);
   resp = bresp;
   bready <= 1'b0;
endtask

// hold keeps rready low for that many cycles once rvalid is seen
task automatic axil_read(input logic [11:0] addr, input int hold,
                         output logic [31:0] data, output logic [1:0] resp);
   araddr  <= addr;
   arvalid <= 1'b1;
   rready  <= 1'b0;
   do @(posedge clk); while (!arready);
   arvalid <= 1'b0;
   do @(posedge clk); while (!rvalid);
   repeat (hold) @(posedge clk);
   rready <= 1'b1;
   @(posedge clk);
   data = rdata;
   resp = rresp;
   rready <= 1'b0;
endtask

`endif

//--- tests/tb_scope.sv
`timescale 1ns/1ns
`default_nettype none

module tb_scope
   import scope_pkg::*;
();

   localparam int depth      = 64;
   localparam int frame_log2 = 4;
   localparam int frame_len  = 1 << frame_log2;
   localparam int clk_period = 20;

   // stream lengths of the tests
   localparam int n_below       = 20;
   localparam int n_fall        = 8;
   localparam int n_ramp        = 6;
   localparam int n_stat_frames = 4;
   localparam int sample_cycles = 2 * (n_below + n_fall) + n_ramp + 1 + 4 * depth
                                  + frame_len + 2 * n_stat_frames * frame_len;
   localparam int axi_accesses  = 20 + depth + 20;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        sample_valid;
   sample_t     sample_data;
   logic [11:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [11:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   integer      seed = 32'hb12c_8c11;

   // trigger and capture model
   sample_t     lvl_m;
   sample_t     prev_m;
   logic        have_prev_m;
   logic        armed_m;
   logic        trig_m;
   logic        done_m;
   sample_t     cap_m [$];

   // frame statistics model
   int          cnt_m;
   int          run_sum_m;
   sample_t     run_min_m;
   sample_t     run_max_m;
   sample_t     min_m;
   sample_t     max_m;
   sample_t     mean_m;
   int          frames_m;

   scope_top i_dut (
      .clk,
      .rst_n,
      .sample_valid,
      .sample_data,
      .awaddr,
      .awvalid,
      .awready,
      .wdata,
      .wstrb,
      .wvalid,
      .wready,
      .bresp,
      .bvalid,
      .bready,
      .araddr,
      .arvalid,
      .arready,
      .rdata,
      .rresp,
      .rvalid,
      .rready
   );

   `include "tb_axil_tasks.svh"

   always #(clk_period / 2) clk = ~clk;

   // response channels hold still under back-pressure
   assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> rvalid)
      else fail($sformatf("rvalid got=%h exp=%h", 1'b0, 1'b1));
   assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> $stable(rdata))
      else fail($sformatf("rdata got=%h exp=%h", $sampled(rdata), $past(rdata)));
   assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> $stable(rresp))
      else fail($sformatf("rresp got=%h exp=%h", $sampled(rresp), $past(rresp)));
   assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
      else fail($sformatf("bvalid got=%h exp=%h", 1'b0, 1'b1));
   assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> $stable(bresp))
      else fail($sformatf("bresp got=%h exp=%h", $sampled(bresp), $past(bresp)));

   // address and data channels are accepted together
   assert property (@(posedge clk) disable iff (!rst_n) wready == awready)
      else fail($sformatf("wready got=%h exp=%h", $sampled(wready), $sampled(awready)));

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   function automatic logic [31:0] status_word();
      return {30'd0, done_m, armed_m};
   endfunction

   task automatic update_models(input sample_t d);
      // rising crossing starts the capture at index 0
      if (armed_m && !trig_m) begin
         if (have_prev_m && (prev_m < lvl_m) && (d >= lvl_m)) begin
            cap_m.push_back(d);
            trig_m = 1'b1;
         end
      end else if (trig_m) begin
         cap_m.push_back(d);
      end
      if (trig_m && (cap_m.size() == depth)) begin
         trig_m  = 1'b0;
         armed_m = 1'b0;
         done_m  = 1'b1;
      end
      prev_m      = d;
      have_prev_m = 1'b1;
      if (cnt_m == 0) begin
         run_min_m = d;
         run_max_m = d;
         run_sum_m = d;
      end else begin
         run_min_m = (d < run_min_m) ? d : run_min_m;
         run_max_m = (d > run_max_m) ? d : run_max_m;
         run_sum_m = run_sum_m + d;
      end
      cnt_m++;
      if (cnt_m == frame_len) begin
         min_m    = run_min_m;
         max_m    = run_max_m;
         mean_m   = sample_t'(run_sum_m >> frame_log2);
         frames_m = frames_m + 1;
         cnt_m    = 0;
      end
   endtask

   task automatic drive_sample(input logic v, input sample_t d);
      sample_valid <= v;
      sample_data  <= d;
      @(posedge clk);
      if (v) begin
         update_models(d);
      end
   endtask

   task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
      logic [1:0] r;
      axil_write(addr, data, r);
      check("bresp", 32'(r), 32'(resp_okay));
   endtask

   // write whose response is left waiting for a few cycles
   task automatic write_bready_late(input logic [11:0] addr, input logic [31:0] data,
                                    input int hold);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= 4'hf;
      wvalid  <= 1'b1;
      bready  <= 1'b0;
      do @(posedge clk); while (!awready);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      do @(posedge clk); while (!bvalid);
      repeat (hold) @(posedge clk);
      bready <= 1'b1;
      @(posedge clk);
      check("bresp", 32'(bresp), 32'(resp_okay));
      bready <= 1'b0;
   endtask

   task automatic expect_read(input logic [11:0] addr, input int hold, input string name,
                              input logic [31:0] exp, input logic [1:0] exp_resp);
      logic [31:0] data;
      logic [1:0]  r;
      axil_read(addr, hold, data, r);
      check({name, " rresp"}, 32'(r), 32'(exp_resp));
      check(name, data, exp);
   endtask

   task automatic arm_trigger();
      write_reg(reg_ctrl[11:0], 32'h1);
      armed_m = 1'b1;
      trig_m  = 1'b0;
      done_m  = 1'b0;
      cap_m.delete();
   endtask

   initial begin
      int          n;
      logic [31:0] r;
      rst_n        <= 1'b0;
      sample_valid <= 1'b0;
      sample_data  <= '0;
      awaddr       <= '0;
      awvalid      <= 1'b0;
      wdata        <= '0;
      wstrb        <= '0;
      wvalid       <= 1'b0;
      bready       <= 1'b0;
      araddr       <= '0;
      arvalid      <= 1'b0;
      rready       <= 1'b0;
      lvl_m        = '0;
      prev_m       = '0;
      have_prev_m  = 1'b0;
      armed_m      = 1'b0;
      trig_m       = 1'b0;
      done_m       = 1'b0;
      cnt_m        = 0;
      run_sum_m    = 0;
      run_min_m    = '0;
      run_max_m    = '0;
      min_m        = '0;
      max_m        = '0;
      mean_m       = '0;
      frames_m     = 0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      // everything reads zero after reset
      expect_read(reg_status[11:0], 0, "status", 32'h0, resp_okay);
      expect_read(reg_ctrl[11:0], 0, "ctrl", 32'h0, resp_okay);
      expect_read(reg_level[11:0], 0, "level", 32'h0, resp_okay);
      expect_read(reg_min[11:0], 0, "min", 32'h0, resp_okay);
      expect_read(reg_max[11:0], 0, "max", 32'h0, resp_okay);
      expect_read(reg_mean[11:0], 0, "mean", 32'h0, resp_okay);
      expect_read(reg_frames[11:0], 0, "frames", 32'h0, resp_okay);

      // level register, read-only write, unmapped reads, back-pressure
      write_reg(reg_level[11:0], 32'habcd_e5a3);
      lvl_m = 12'h5a3;
      expect_read(reg_level[11:0], 0, "level", 32'(lvl_m), resp_okay);
      write_reg(reg_status[11:0], 32'hffff_ffff);
      expect_read(reg_status[11:0], 0, "status", status_word(), resp_okay);
      expect_read(12'h01c, 0, "unmapped rdata", 32'h0, resp_slverr);
      expect_read(12'h200, 0, "past buffer rdata", 32'h0, resp_slverr);
      expect_read(reg_level[11:0], 5, "level held", 32'(lvl_m), resp_okay);
      write_bready_late(reg_level[11:0], 32'h0000_0800, 4);
      lvl_m = 12'h800;
      expect_read(reg_level[11:0], 3, "level", 32'(lvl_m), resp_okay);

      // armed capture of a rising crossing
      arm_trigger();
      expect_read(reg_status[11:0], 0, "status", status_word(), resp_okay);
      for (n = 0; n < n_below; n++) begin
         r = rand_word();
         drive_sample(1'b1, {1'b0, r[10:0]});
      end
      for (n = 0; n < n_fall; n++) begin
         drive_sample(1'b1, sample_t'(12'h7f0 - 16 * n));
      end
      // 0x800 is the first sample at the level
      for (n = 0; n < n_ramp; n++) begin
         drive_sample(1'b1, sample_t'(12'h7c0 + 16 * n));
      end
      n = 0;
      while (!done_m && (n < 4 * depth)) begin
         r = rand_word();
         drive_sample(r[31], r[11:0]);
         n++;
      end
      sample_valid <= 1'b0;
      check("captured count", 32'(cap_m.size()), depth);
      expect_read(reg_status[11:0], 0, "status", status_word(), resp_okay);
      expect_read(buf_base[11:0], 0, "buf[0]", 32'h800, resp_okay);
      for (n = 0; n < depth; n++) begin
         expect_read(12'(buf_base + 4 * n), 0, $sformatf("buf[%0d]", n), 32'(cap_m[n]),
                     resp_okay);
      end

      // rearm, then no rising crossing
      drive_sample(1'b1, 12'hc00);
      sample_valid <= 1'b0;
      arm_trigger();
      expect_read(reg_status[11:0], 0, "status", status_word(), resp_okay);
      for (n = 0; n < n_fall; n++) begin
         drive_sample(1'b1, sample_t'(12'hc00 - 12'h100 * n));
      end
      for (n = 0; n < n_below; n++) begin
         r = rand_word();
         drive_sample(1'b1, {1'b0, r[10:0]});
      end
      sample_valid <= 1'b0;
      check("model status", status_word(), 32'h1);
      expect_read(reg_status[11:0], 0, "status", status_word(), resp_okay);

      // whole frames with gaps in sample_valid
      while (cnt_m != 0) begin
         r = rand_word();
         drive_sample(1'b1, r[11:0]);
      end
      n = frames_m + n_stat_frames;
      while (frames_m < n) begin
         r = rand_word();
         drive_sample(r[30] | r[29], r[11:0]);
      end
      sample_valid <= 1'b0;
      expect_read(reg_min[11:0], 0, "min", 32'(min_m), resp_okay);
      expect_read(reg_max[11:0], 0, "max", 32'(max_m), resp_okay);
      expect_read(reg_mean[11:0], 0, "mean", 32'(mean_m), resp_okay);
      expect_read(reg_frames[11:0], 0, "frames", 32'(frames_m), resp_okay);

      $display("STATUS: PASS");
      $finish;
   end

   initial begin
      #(2 * (sample_cycles + 50 * axi_accesses) * clk_period);
      $display("STATUS: FAIL");
      $display("timeout: the run did not finish within its cycle budget");
      $fatal(1, "watchdog timeout");
   end

endmodule

`default_nettype wire

//--- hw/scope_top.sv
`timescale 1ns/1ns
`default_nettype none

module scope_top
   import scope_pkg::*;
#(
   parameter int depth      = 64,
   parameter int frame_log2 = 4
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        sample_valid,
   input  sample_t     sample_data,
   input  logic [11:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [11:0] araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready
);

   capture_if #(.depth(depth)) cap_bus ();
   stats_if                    stats_bus ();

   // both blocks see the same sample stream
   trigger_capture #(.depth(depth)) u_trigger_capture (
      .clk,
      .rst_n,
      .sample_valid,
      .sample_data,
      .cap (cap_bus)
   );

   sample_stats #(.frame_log2(frame_log2)) u_sample_stats (
      .clk,
      .rst_n,
      .sample_valid,
      .sample_data,
      .st  (stats_bus)
   );

   scope_regs #(.depth(depth)) u_scope_regs (
      .clk,
      .rst_n,
      .awaddr,
      .awvalid,
      .awready,
      .wdata,
      .wstrb,
      .wvalid,
      .wready,
      .bresp,
      .bvalid,
      .bready,
      .araddr,
      .arvalid,
      .arready,
      .rdata,
      .rresp,
      .rvalid,
      .rready,
      .cap (cap_bus),
      .st  (stats_bus)
   );

endmodule

`default_nettype wire

//--- hw/scope_regs.sv
`timescale 1ns/1ns
`default_nettype none

module scope_regs
   import scope_pkg::*;
#(
   parameter int depth = 64
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [11:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [11:0] araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   capture_if.host     cap,
   stats_if.sink       st
);

   localparam int          aw     = idx_w(depth);
   localparam logic [11:0] buf_lo = buf_base[11:0];
   localparam logic [11:0] buf_hi = 12'(buf_base + 4 * depth);

   typedef enum logic [3:0] {
      sel_zero,
      sel_level,
      sel_status,
      sel_min,
      sel_max,
      sel_mean,
      sel_frames,
      sel_buf,
      sel_err
   } rd_sel_t;

   logic        wr_rdy_q;
   logic        bvalid_q;
   logic        arm_q;
   sample_t     level_q;
   sample_t     min_q;
   sample_t     max_q;
   sample_t     mean_q;
   logic [31:0] frames_q;
   logic        arready_q;
   logic        rd_s1_q;
   logic        rvalid_q;
   rd_sel_t     sel_q;
   logic [31:0] rdata_q;
   logic [1:0]  rresp_q;

   logic        wr_hs;
   logic        ar_hs;
   rd_sel_t     sel;
   logic [11:0] buf_off;
   logic [31:0] rd_word;

   assign wr_hs = wr_rdy_q && awvalid && wvalid;
   assign ar_hs = arready_q && arvalid;

   // write channel, level register and arm strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_rdy_q <= 1'b0;
         bvalid_q <= 1'b0;
         arm_q    <= 1'b0;
         level_q  <= '0;
      end else begin
         wr_rdy_q <= awvalid && wvalid && !bvalid_q && !wr_rdy_q;
         arm_q    <= wr_hs && (awaddr == reg_ctrl[11:0]) && wstrb[0] && wdata[0];
         if (wr_hs) begin
            bvalid_q <= 1'b1;
         end else if (bready) begin
            bvalid_q <= 1'b0;
         end
         if (wr_hs && (awaddr == reg_level[11:0])) begin
            for (int i = 0; i < sample_w; i++) begin
               if (wstrb[i / 8]) begin
                  level_q[i] <= wdata[i];
               end
            end
         end
      end
   end

   // snapshot of the last completed frame
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         min_q    <= '0;
         max_q    <= '0;
         mean_q   <= '0;
         frames_q <= '0;
      end else if (st.upd) begin
         min_q    <= st.min_val;
         max_q    <= st.max_val;
         mean_q   <= st.mean_val;
         frames_q <= st.frame_count;
      end
   end

   // address decode in the handshake cycle
   always_comb begin
      sel = sel_err;
      if ((araddr >= buf_lo) && (araddr < buf_hi) && (araddr[1:0] == 2'b00)) begin
         sel = sel_buf;
      end else begin
         case (araddr)
            reg_ctrl[11:0]:   sel = sel_zero;
            reg_level[11:0]:  sel = sel_level;
            reg_status[11:0]: sel = sel_status;
            reg_min[11:0]:    sel = sel_min;
            reg_max[11:0]:    sel = sel_max;
            reg_mean[11:0]:   sel = sel_mean;
            reg_frames[11:0]: sel = sel_frames;
            default:          sel = sel_err;
         endcase
      end
   end

   // buffer word index goes out with the address
   assign buf_off     = araddr - buf_lo;
   assign cap.rd_addr = buf_off[aw+1:2];

   always_comb begin
      case (sel_q)
         sel_level:  rd_word = 32'(level_q);
         sel_status: rd_word = {30'd0, cap.done, cap.armed};
         sel_min:    rd_word = 32'(min_q);
         sel_max:    rd_word = 32'(max_q);
         sel_mean:   rd_word = 32'(mean_q);
         sel_frames: rd_word = frames_q;
         sel_buf:    rd_word = 32'(cap.rd_data);
         default:    rd_word = '0;
      endcase
   end

   // read channel with one read in flight
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arready_q <= 1'b0;
         rd_s1_q   <= 1'b0;
         rvalid_q  <= 1'b0;
      end else begin
         rd_s1_q <= ar_hs;
         if (ar_hs) begin
            arready_q <= 1'b0;
         end else if (!rd_s1_q && (!rvalid_q || rready)) begin
            arready_q <= 1'b1;
         end
         if (rd_s1_q) begin
            rvalid_q <= 1'b1;
         end else if (rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         sel_q <= sel;
      end
      if (rd_s1_q) begin
         rdata_q <= rd_word;
         rresp_q <= (sel_q == sel_err) ? resp_slverr : resp_okay;
      end
   end

   assign awready   = wr_rdy_q;
   assign wready    = wr_rdy_q;
   assign bvalid    = bvalid_q;
   // writes always complete
   assign bresp     = resp_okay;
   assign arready   = arready_q;
   assign rvalid    = rvalid_q;
   assign rdata     = rdata_q;
   assign rresp     = rresp_q;
   assign cap.arm   = arm_q;
   assign cap.level = level_q;

endmodule

`default_nettype wire

//--- hw/sample_stats.sv
`timescale 1ns/1ns
`default_nettype none

module sample_stats
   import scope_pkg::*;
#(
   parameter int frame_log2 = 4
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     sample_valid,
   input  sample_t  sample_data,
   stats_if.source  st
);

   localparam int            cw       = (frame_log2 > 0) ? frame_log2 : 1;
   localparam int            sw       = sample_w + frame_log2;
   localparam logic [cw-1:0] last_cnt = cw'((1 << frame_log2) - 1);

   logic [cw-1:0] cnt_q;
   sample_t       run_min_q;
   sample_t       run_max_q;
   logic [sw-1:0] run_sum_q;
   sample_t       min_q;
   sample_t       max_q;
   sample_t       mean_q;
   logic [31:0]   frames_q;
   logic          upd_q;

   sample_t       min_nxt;
   sample_t       max_nxt;
   logic [sw-1:0] sum_nxt;
   logic          first;
   logic          last;

   assign first = (cnt_q == '0);
   assign last  = (cnt_q == last_cnt);

   // running values including the current sample
   always_comb begin
      if (first) begin
         min_nxt = sample_data;
         max_nxt = sample_data;
         sum_nxt = sw'(sample_data);
      end else begin
         min_nxt = (sample_data < run_min_q) ? sample_data : run_min_q;
         max_nxt = (sample_data > run_max_q) ? sample_data : run_max_q;
         sum_nxt = run_sum_q + sw'(sample_data);
      end
   end

   always_ff @(posedge clk) begin
      if (sample_valid) begin
         run_min_q <= min_nxt;
         run_max_q <= max_nxt;
         run_sum_q <= sum_nxt;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt_q    <= '0;
         min_q    <= '0;
         max_q    <= '0;
         mean_q   <= '0;
         frames_q <= '0;
         upd_q    <= 1'b0;
      end else begin
         upd_q <= 1'b0;
         if (sample_valid) begin
            cnt_q <= last ? '0 : cnt_q + 1'b1;
            // mean at frame end is the truncated sum / 2**frame_log2
            if (last) begin
               min_q    <= min_nxt;
               max_q    <= max_nxt;
               mean_q   <= sample_t'(sum_nxt >> frame_log2);
               frames_q <= frames_q + 32'd1;
               upd_q    <= 1'b1;
            end
         end
      end
   end

   assign st.min_val     = min_q;
   assign st.max_val     = max_q;
   assign st.mean_val    = mean_q;
   assign st.frame_count = frames_q;
   assign st.upd         = upd_q;

endmodule

`default_nettype wire

//--- hw/trigger_capture.sv
`timescale 1ns/1ns
`default_nettype none

module trigger_capture
   import scope_pkg::*;
#(
   parameter int depth = 64
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       sample_valid,
   input  sample_t    sample_data,
   capture_if.capture cap
);

   localparam int            aw       = idx_w(depth);
   localparam logic [aw-1:0] last_idx = aw'(depth - 1);

   sample_t       mem [depth];
   sample_t       prev_q;
   sample_t       rd_data_q;
   logic          have_prev_q;
   logic          armed_q;
   logic          trig_q;
   logic          done_q;
   logic [aw-1:0] cnt_q;

   logic          crossing;
   logic          hit;
   logic          wr_en;
   logic [aw-1:0] wr_idx;

   // rising crossing against the previous valid sample
   assign crossing = have_prev_q && (prev_q < cap.level) && (sample_data >= cap.level);
   assign hit      = armed_q && !trig_q && sample_valid && crossing;
   assign wr_en    = hit || (trig_q && sample_valid);
   // cnt_q stays zero until the trigger sample lands at index 0
   assign wr_idx   = cnt_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         have_prev_q <= 1'b0;
      end else if (sample_valid) begin
         have_prev_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (sample_valid) begin
         prev_q <= sample_data;
      end
   end

   // arm, wait for crossing, fill, done
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         armed_q <= 1'b0;
         trig_q  <= 1'b0;
         done_q  <= 1'b0;
         cnt_q   <= '0;
      end else if (cap.arm) begin
         armed_q <= 1'b1;
         trig_q  <= 1'b0;
         done_q  <= 1'b0;
         cnt_q   <= '0;
      end else if (wr_en) begin
         if (wr_idx == last_idx) begin
            armed_q <= 1'b0;
            trig_q  <= 1'b0;
            done_q  <= 1'b1;
            cnt_q   <= '0;
         end else begin
            trig_q  <= 1'b1;
            cnt_q   <= wr_idx + 1'b1;
         end
      end
   end

   // sample memory with a registered read port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_idx] <= sample_data;
      end
      rd_data_q <= mem[cap.rd_addr];
   end

   assign cap.armed   = armed_q;
   assign cap.done    = done_q;
   assign cap.rd_data = rd_data_q;

endmodule

`default_nettype wire

//--- hw/stats_if.sv
`timescale 1ns/1ns
`default_nettype none

interface stats_if
   import scope_pkg::*;
();

   sample_t     min_val;
   sample_t     max_val;
   sample_t     mean_val;
   logic [31:0] frame_count;
   // one cycle strobe with each new result set
   logic        upd;

   modport source (
      output min_val, max_val, mean_val, frame_count, upd
   );

   modport sink (
      input  min_val, max_val, mean_val, frame_count, upd
   );

endinterface

`default_nettype wire

//--- hw/capture_if.sv
`timescale 1ns/1ns
`default_nettype none

interface capture_if
   import scope_pkg::*;
#(
   parameter int depth = 64
) ();

   // driven by the register block
   logic                    arm;
   sample_t                 level;
   logic [idx_w(depth)-1:0] rd_addr;

   // driven by the capture block with rd_data one cycle after rd_addr
   logic                    armed;
   logic                    done;
   sample_t                 rd_data;

   modport capture (
      input  arm, level, rd_addr,
      output armed, done, rd_data
   );

   modport host (
      output arm, level, rd_addr,
      input  armed, done, rd_data
   );

endinterface

`default_nettype wire

//--- hw/scope_pkg.sv
`default_nettype none

package scope_pkg;

   // one adc sample
   localparam int sample_w = 12;

   typedef logic [sample_w-1:0] sample_t;

   // register byte offsets
   localparam logic [31:0] reg_ctrl   = 32'h000;
   localparam logic [31:0] reg_level  = 32'h004;
   localparam logic [31:0] reg_status = 32'h008;
   localparam logic [31:0] reg_min    = 32'h00C;
   localparam logic [31:0] reg_max    = 32'h010;
   localparam logic [31:0] reg_mean   = 32'h014;
   localparam logic [31:0] reg_frames = 32'h018;
   localparam logic [31:0] buf_base   = 32'h100;

   // axi response codes
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // index width for a buffer of n words
   function automatic int idx_w(input int n);
      return (n > 1) ? $clog2(n) : 1;
   endfunction

endpackage

`default_nettype wire
